//--- list.f
logic/oramPkg.sv
logic/stash.sv
logic/pathReadBuffer.sv
logic/posMapFrontend.sv
logic/pathBackend.sv
logic/pathOramTop.sv
tests/pathOramTop_checker.sv
tests/pathOramTb.sv

//--- logic/oramPkg.sv
// ----------------------------------------------------------
// Fixed geometry: 4 levels, 8 leaves, 2 slots per bucket
// One DRAM beat carries exactly one bucket slot
// ----------------------------------------------------------
package oramPkg;

	// ----------------------------------------------------------
	// Tree geometry
	// ----------------------------------------------------------
	localparam int treeLevels = 4;
	localparam int bucketSlots = 2;
	localparam int leafWidth = 3;
	localparam int addrWidth = 3;
	localparam int dataWidth = 16;
	// Heap order, root is bucket 0
	localparam int bucketAddrWidth = 4;
	localparam int entryWidth = 1 + addrWidth + leafWidth + dataWidth;
	localparam int stashDepth = 8;

	// Derived sizes
	localparam int pathBeats = treeLevels * bucketSlots;
	localparam int levelWidth = $clog2(treeLevels);
	localparam int slotWidth = $clog2(bucketSlots);
	localparam int beatWidth = $clog2(pathBeats);
	localparam int stashIdxWidth = $clog2(stashDepth);

	// Nonzero start value of the leaf generator
	localparam logic [15:0] leafSeed = 16'hACE1;

	// ----------------------------------------------------------
	// Bucket entry, MSB first: valid, addr, leaf, data
	// ----------------------------------------------------------
	typedef struct packed {
		logic valid;
		logic [addrWidth-1:0] addr;
		logic [leafWidth-1:0] leaf;
		logic [dataWidth-1:0] data;
	} oramEntry;

	typedef enum logic {opRead, opWrite} oramOp;
	typedef enum logic {dramRead, dramWrite} dramOp;

	typedef enum logic [2:0] {
		idle, readCmd, readData, serve, evict, writeCmd, writeData
	} backendState;

endpackage

//--- logic/pathBackend.sv
// ----------------------------------------------------------
// Command fields must stay stable while beValid is high;
// beReady pulses on the last write beat of the path
// ----------------------------------------------------------
module pathBackend import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	input oramOp beCmd,
	input logic [addrWidth-1:0] beAddr,
	input logic [leafWidth-1:0] oldLeaf,
	input logic [leafWidth-1:0] newLeaf,
	input logic beValid,
	output logic beReady,
	input logic [dataWidth-1:0] storeData,
	input logic storeValid,
	output logic storeReady,
	output logic [dataWidth-1:0] loadData,
	output logic loadValid,
	input logic loadReady,
	output logic [bucketAddrWidth-1:0] DRAMAddress,
	output dramOp DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic [entryWidth-1:0] bufData,
	input logic bufValid,
	output logic bufReady,
	output logic [entryWidth-1:0] DRAMWriteData,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady
);

	backendState state;
	logic [levelWidth-1:0] level;
	logic [beatWidth-1:0] beatCnt;
	logic [slotWidth-1:0] slot;
	oramEntry wrData;
	oramEntry bufEntry;

	// Stash side
	logic hit;
	logic [stashIdxWidth-1:0] hitIndex;
	logic [dataWidth-1:0] stashData;
	logic stWriteEn;
	logic [stashIdxWidth-1:0] stWriteIndex;
	oramEntry stWriteEntry;
	logic [stashIdxWidth-1:0] freeIndex;
	logic evictValid;
	oramEntry evictEntry;
	logic serveDone;
	logic lastSlot;

	// Heap-order bucket on the path to leaf at the given level
	function automatic logic [bucketAddrWidth-1:0] bucketOf(
		input logic [leafWidth-1:0] leaf,
		input logic [levelWidth-1:0] lvl
	);
		logic [bucketAddrWidth-1:0] base;
		logic [bucketAddrWidth-1:0] offs;
		base = (bucketAddrWidth'(1) << lvl) - 1'b1;
		offs = bucketAddrWidth'(leaf >> (leafWidth - lvl));
		return base + offs;
	endfunction

	assign bufEntry = oramEntry'(bufData);
	assign lastSlot = (slot == slotWidth'(bucketSlots - 1));

	// ----------------------------------------------------------
	// Serve step
	// ----------------------------------------------------------
	assign loadValid = (state == serve) && (beCmd == opRead);
	// Never-written block reads as zero
	assign loadData = hit ? stashData : '0;
	assign storeReady = (state == serve) && (beCmd == opWrite);
	assign serveDone = (beCmd == opWrite) ? storeReady && storeValid : loadValid && loadReady;

	// Stash write: path fill during readData, remap during serve
	always_comb begin
		stWriteEn = 1'b0;
		stWriteIndex = freeIndex;
		stWriteEntry = bufEntry;
		if (state == readData) begin
			stWriteEn = bufValid && bufEntry.valid;
		end else if (state == serve) begin
			stWriteEn = serveDone;
			stWriteIndex = hit ? hitIndex : freeIndex;
			stWriteEntry.valid = 1'b1;
			stWriteEntry.addr = beAddr;
			stWriteEntry.leaf = newLeaf;
			stWriteEntry.data = (beCmd == opWrite) ? storeData : loadData;
		end
	end

	// ----------------------------------------------------------
	// DRAM side
	// ----------------------------------------------------------
	assign DRAMCommandValid = (state == readCmd) || (state == writeCmd);
	assign DRAMCommand = (state == writeCmd) ? dramWrite : dramRead;
	assign DRAMAddress = bucketOf(oldLeaf, level);
	assign bufReady = (state == readData);
	assign DRAMWriteDataValid = (state == writeData);
	assign DRAMWriteData = wrData;
	assign beReady = (state == writeData) && DRAMWriteDataReady && lastSlot && (level == '0);

	// Sequencer
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			level <= '0;
			beatCnt <= '0;
			slot <= '0;
		end else begin
			case (state)
				idle: begin
					if (beValid) begin
						state <= readCmd;
						level <= '0;
					end
				end
				// Root to leaf
				readCmd: begin
					if (DRAMCommandReady) begin
						if (level == levelWidth'(treeLevels - 1)) begin
							state <= readData;
							beatCnt <= '0;
						end else begin
							level <= level + 1'b1;
						end
					end
				end
				readData: begin
					if (bufValid) begin
						if (beatCnt == beatWidth'(pathBeats - 1)) begin
							state <= serve;
						end else begin
							beatCnt <= beatCnt + 1'b1;
						end
					end
				end
				serve: begin
					if (serveDone) begin
						state <= evict;
						level <= levelWidth'(treeLevels - 1);
						slot <= '0;
					end
				end
				// Command goes out once per bucket, before its first beat
				evict: state <= (slot == '0) ? writeCmd : writeData;
				writeCmd: begin
					if (DRAMCommandReady) begin
						state <= writeData;
					end
				end
				writeData: begin
					if (DRAMWriteDataReady) begin
						state <= evict;
						if (lastSlot) begin
							slot <= '0;
							// Leaf back up to root
							if (level == '0) begin
								state <= idle;
							end else begin
								level <= level - 1'b1;
							end
						end else begin
							slot <= slot + 1'b1;
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// Latch the chosen block, or an empty slot
	always_ff @(posedge Clock) begin
		if (state == evict) begin
			wrData <= evictValid ? evictEntry : '0;
		end
	end

	stash blockStash (
		.Clock(Clock),
		.rstN(rstN),
		.lookupAddr(beAddr),
		.hit(hit),
		.hitIndex(hitIndex),
		.readData(stashData),
		.writeEn(stWriteEn),
		.writeIndex(stWriteIndex),
		.writeEntry(stWriteEntry),
		.freeIndex(freeIndex),
		.evictLeaf(oldLeaf),
		.evictLevel(level),
		.evictValid(evictValid),
		.evictIndex(),
		.evictEntry(evictEntry),
		.clearEn((state == evict) && evictValid)
	);

endmodule

//--- logic/pathOramTop.sv
// ----------------------------------------------------------
// Client and DRAM ports only; no encryption or write mask
// ----------------------------------------------------------
module pathOramTop import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	input oramOp Cmd,
	input logic [addrWidth-1:0] PAddr,
	input logic CmdValid,
	output logic CmdReady,
	input logic [dataWidth-1:0] DataIn,
	input logic DataInValid,
	output logic DataInReady,
	output logic [dataWidth-1:0] DataOut,
	output logic DataOutValid,
	input logic DataOutReady,
	output logic [bucketAddrWidth-1:0] DRAMAddress,
	output dramOp DRAMCommand,
	output logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic [entryWidth-1:0] DRAMReadData,
	input logic DRAMReadDataValid,
	output logic [entryWidth-1:0] DRAMWriteData,
	output logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady
);

	// ----------------------------------------------------------
	// Frontend to backend
	// ----------------------------------------------------------
	oramOp beCmd;
	logic [addrWidth-1:0] beAddr;
	logic [leafWidth-1:0] oldLeaf;
	logic [leafWidth-1:0] newLeaf;
	logic beValid;
	logic beReady;
	logic [dataWidth-1:0] storeData;
	logic storeValid;
	logic storeReady;
	logic [dataWidth-1:0] loadData;
	logic loadValid;
	logic loadReady;

	// Read buffer to backend
	logic [entryWidth-1:0] bufData;
	logic bufValid;
	logic bufReady;

	posMapFrontend frontEnd (
		.Clock(Clock),
		.rstN(rstN),
		.Cmd(Cmd),
		.PAddr(PAddr),
		.CmdValid(CmdValid),
		.CmdReady(CmdReady),
		.DataIn(DataIn),
		.DataInValid(DataInValid),
		.DataInReady(DataInReady),
		.DataOut(DataOut),
		.DataOutValid(DataOutValid),
		.DataOutReady(DataOutReady),
		.beCmd(beCmd),
		.beAddr(beAddr),
		.oldLeaf(oldLeaf),
		.newLeaf(newLeaf),
		.beValid(beValid),
		.beReady(beReady),
		.storeData(storeData),
		.storeValid(storeValid),
		.storeReady(storeReady),
		.loadData(loadData),
		.loadValid(loadValid),
		.loadReady(loadReady)
	);

	pathBackend backEnd (
		.Clock(Clock),
		.rstN(rstN),
		.beCmd(beCmd),
		.beAddr(beAddr),
		.oldLeaf(oldLeaf),
		.newLeaf(newLeaf),
		.beValid(beValid),
		.beReady(beReady),
		.storeData(storeData),
		.storeValid(storeValid),
		.storeReady(storeReady),
		.loadData(loadData),
		.loadValid(loadValid),
		.loadReady(loadReady),
		.DRAMAddress(DRAMAddress),
		.DRAMCommand(DRAMCommand),
		.DRAMCommandValid(DRAMCommandValid),
		.DRAMCommandReady(DRAMCommandReady),
		.bufData(bufData),
		.bufValid(bufValid),
		.bufReady(bufReady),
		.DRAMWriteData(DRAMWriteData),
		.DRAMWriteDataValid(DRAMWriteDataValid),
		.DRAMWriteDataReady(DRAMWriteDataReady)
	);

	// DRAM return data, path deep
	pathReadBuffer pathBuf (
		.Clock(Clock),
		.rstN(rstN),
		.inData(DRAMReadData),
		.inValid(DRAMReadDataValid),
		.outData(bufData),
		.outValid(bufValid),
		.outReady(bufReady)
	);

endmodule

//--- logic/pathReadBuffer.sv
// ----------------------------------------------------------
// Holds one full path; the DRAM side has no back-pressure
// ----------------------------------------------------------
module pathReadBuffer import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	input logic [entryWidth-1:0] inData,
	input logic inValid,
	output logic [entryWidth-1:0] outData,
	output logic outValid,
	input logic outReady
);

	logic [entryWidth-1:0] mem [pathBeats];
	logic [beatWidth-1:0] wrPtr;
	logic [beatWidth-1:0] rdPtr;
	logic [beatWidth:0] count;
	logic pop;

	assign outValid = (count != '0);
	assign outData = mem[rdPtr];
	assign pop = outValid && outReady;

	// Pointers wrap naturally at path depth
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (inValid) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			count <= count + (beatWidth + 1)'(inValid) - (beatWidth + 1)'(pop);
		end
	end

	// Visible at the output one cycle after the write
	always_ff @(posedge Clock) begin
		if (inValid) begin
			mem[wrPtr] <= inData;
		end
	end

endmodule

//--- logic/posMapFrontend.sv
// ----------------------------------------------------------
// One access in flight; CmdReady returns after the backend
// finishes and any read result has been taken
// ----------------------------------------------------------
module posMapFrontend import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	input oramOp Cmd,
	input logic [addrWidth-1:0] PAddr,
	input logic CmdValid,
	output logic CmdReady,
	input logic [dataWidth-1:0] DataIn,
	input logic DataInValid,
	output logic DataInReady,
	output logic [dataWidth-1:0] DataOut,
	output logic DataOutValid,
	input logic DataOutReady,
	output oramOp beCmd,
	output logic [addrWidth-1:0] beAddr,
	output logic [leafWidth-1:0] oldLeaf,
	output logic [leafWidth-1:0] newLeaf,
	output logic beValid,
	input logic beReady,
	output logic [dataWidth-1:0] storeData,
	output logic storeValid,
	input logic storeReady,
	input logic [dataWidth-1:0] loadData,
	input logic loadValid,
	output logic loadReady
);

	// Position map, one leaf per program block
	logic [leafWidth-1:0] posMap [2**addrWidth];
	logic [$bits(leafSeed)-1:0] lfsr;
	logic [$bits(leafSeed)-1:0] shiftA;
	logic [$bits(leafSeed)-1:0] shiftB;
	logic [$bits(leafSeed)-1:0] lfsrNext;

	logic busy;
	// Backend handshake seen, waiting on result drain
	logic beDone;
	// Write command taken but its data beat not yet
	logic wantData;
	logic cmdFire;
	logic dataFire;

	// ----------------------------------------------------------
	// Xorshift leaf generator, free running
	// ----------------------------------------------------------
	always_comb begin
		shiftA = lfsr ^ (lfsr << 7);
		shiftB = shiftA ^ (shiftA >> 9);
		lfsrNext = shiftB ^ (shiftB << 8);
	end

	assign CmdReady = !busy;
	assign cmdFire = CmdValid && CmdReady;
	// Data beat may ride along with its command
	assign DataInReady = !storeValid && (wantData || (cmdFire && Cmd == opWrite));
	assign dataFire = DataInValid && DataInReady;
	// Single result slot toward the client
	assign loadReady = !DataOutValid;

	// Control state
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			lfsr <= leafSeed;
			busy <= 1'b0;
			beValid <= 1'b0;
			beDone <= 1'b0;
			wantData <= 1'b0;
			storeValid <= 1'b0;
			DataOutValid <= 1'b0;
			for (int i = 0; i < 2**addrWidth; i++) begin
				posMap[i] <= '0;
			end
		end else begin
			lfsr <= lfsrNext;
			if (cmdFire) begin
				busy <= 1'b1;
				beValid <= 1'b1;
				// Remap now, old leaf goes out with the command
				posMap[PAddr] <= lfsr[leafWidth-1:0];
			end
			if (dataFire) begin
				wantData <= 1'b0;
			end else if (cmdFire) begin
				wantData <= (Cmd == opWrite);
			end
			if (beValid && beReady) begin
				beValid <= 1'b0;
				beDone <= 1'b1;
			end
			// Release only once the read result has left
			if (beDone && !DataOutValid) begin
				busy <= 1'b0;
				beDone <= 1'b0;
			end
			if (dataFire) begin
				storeValid <= 1'b1;
			end else if (storeValid && storeReady) begin
				storeValid <= 1'b0;
			end
			if (loadValid && loadReady) begin
				DataOutValid <= 1'b1;
			end else if (DataOutValid && DataOutReady) begin
				DataOutValid <= 1'b0;
			end
		end
	end

	// Payload registers
	always_ff @(posedge Clock) begin
		if (cmdFire) begin
			beCmd <= Cmd;
			beAddr <= PAddr;
			oldLeaf <= posMap[PAddr];
			newLeaf <= lfsr[leafWidth-1:0];
		end
		if (dataFire) begin
			storeData <= DataIn;
		end
		if (loadValid && loadReady) begin
			DataOut <= loadData;
		end
	end

endmodule

//--- logic/stash.sv
// ----------------------------------------------------------
// No overflow check; 8 blocks total fit in 8 entries
// ----------------------------------------------------------
module stash import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	input logic [addrWidth-1:0] lookupAddr,
	output logic hit,
	output logic [stashIdxWidth-1:0] hitIndex,
	output logic [dataWidth-1:0] readData,
	input logic writeEn,
	input logic [stashIdxWidth-1:0] writeIndex,
	input oramEntry writeEntry,
	output logic [stashIdxWidth-1:0] freeIndex,
	input logic [leafWidth-1:0] evictLeaf,
	input logic [levelWidth-1:0] evictLevel,
	output logic evictValid,
	output logic [stashIdxWidth-1:0] evictIndex,
	output oramEntry evictEntry,
	input logic clearEn
);

	oramEntry entries [stashDepth];
	logic [stashDepth-1:0] valid;
	logic [stashDepth-1:0] pathMatch;

	// Leaves share the path down to evictLevel
	always_comb begin
		for (int i = 0; i < stashDepth; i++) begin
			pathMatch[i] = (entries[i].leaf >> (leafWidth - evictLevel)) ==
				(evictLeaf >> (leafWidth - evictLevel));
		end
	end

	// ----------------------------------------------------------
	// Priority encoders, lowest index wins
	// ----------------------------------------------------------
	always_comb begin
		hit = 1'b0;
		hitIndex = '0;
		freeIndex = '0;
		evictValid = 1'b0;
		evictIndex = '0;
		// Walk downward so the last assignment is the lowest match
		for (int i = stashDepth - 1; i >= 0; i--) begin
			if (valid[i] && entries[i].addr == lookupAddr) begin
				hit = 1'b1;
				hitIndex = stashIdxWidth'(i);
			end
			if (!valid[i]) begin
				freeIndex = stashIdxWidth'(i);
			end
			if (valid[i] && pathMatch[i]) begin
				evictValid = 1'b1;
				evictIndex = stashIdxWidth'(i);
			end
		end
	end

	assign readData = entries[hitIndex].data;
	assign evictEntry = entries[evictIndex];

	// Valid bits
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			valid <= '0;
		end else if (writeEn) begin
			valid[writeIndex] <= writeEntry.valid;
		end else if (clearEn) begin
			valid[evictIndex] <= 1'b0;
		end
	end

	// Entry storage
	always_ff @(posedge Clock) begin
		if (writeEn) begin
			entries[writeIndex] <= writeEntry;
		end
	end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the Path ORAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pathOramTb -f list.f -o pathOramSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/pathOramSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "TEST PASS" sim.log; then
	exit 0
fi
echo "No pass line found in sim.log"
exit 1

//--- tests/oramTrace.txt
# columns in hex: op (0 read, 1 write), addr, write data, expected read, back-pressure
# expected read is checked on reads only
0 0 0000 0000 0
0 5 0000 0000 0
0 7 0000 0000 0
1 3 beef 0000 0
0 3 0000 beef 0
1 6 1234 0000 0
0 6 0000 1234 0
1 3 c0de 0000 0
0 3 0000 c0de 0
0 6 0000 1234 0
0 1 0000 0000 0
1 0 a5a5 0000 0
1 7 5a5a 0000 0
0 0 0000 a5a5 0
0 7 0000 5a5a 0
0 3 0000 c0de 0
1 2 0f0f 0000 1
0 2 0000 0f0f 1
1 2 f00d 0000 1
0 2 0000 f00d 1
0 3 0000 c0de 1
0 4 0000 0000 1
1 4 4444 0000 1
0 4 0000 4444 1

//--- tests/pathOramTb.sv
// ----------------------------------------------------------
// Run from the project root so the trace path resolves
// DRAM model answers read commands after a fixed delay
// ----------------------------------------------------------
module pathOramTb import oramPkg::*; ();

	localparam int waitLimit = 3000;
	localparam int readDelay = 3;
	localparam int randomOps = 40;
	localparam int dramBuckets = 15;
	localparam logic [31:0] seed = 32'd76;

	// ----------------------------------------------------------
	// DUT signals
	// ----------------------------------------------------------
	logic Clock = 1'b0;
	logic rstN;
	oramOp Cmd;
	logic [addrWidth-1:0] PAddr;
	logic CmdValid;
	logic CmdReady;
	logic [dataWidth-1:0] DataIn;
	logic DataInValid;
	logic DataInReady;
	logic [dataWidth-1:0] DataOut;
	logic DataOutValid;
	logic DataOutReady = 1'b0;
	logic [bucketAddrWidth-1:0] DRAMAddress;
	dramOp DRAMCommand;
	logic DRAMCommandValid;
	logic DRAMCommandReady = 1'b0;
	logic [entryWidth-1:0] DRAMReadData = '0;
	logic DRAMReadDataValid = 1'b0;
	logic [entryWidth-1:0] DRAMWriteData;
	logic DRAMWriteDataValid;
	logic DRAMWriteDataReady = 1'b0;

	// DRAM model state and traffic log
	logic [entryWidth-1:0] dramMem [dramBuckets][bucketSlots];
	logic [entryWidth-1:0] beatQ [$];
	int beatTime [$];
	dramOp cmdOps [$];
	logic [bucketAddrWidth-1:0] cmdAddrs [$];
	int wrBeats [$];
	logic [bucketAddrWidth-1:0] wrBucket;
	int wrSlot;
	int cycle;
	logic [31:0] readyRnd;
	logic backPressure = 1'b0;

	// Reference model and bookkeeping
	logic [dataWidth-1:0] shadow [2**addrWidth];
	logic [31:0] opsRnd;
	int checks;
	int errors;
	bit timedOut;

	always #5 Clock = ~Clock;

	pathOramTop u_pathOramTop (.*);

	bind pathOramTop pathOramTop_checker handshakeChecks (.*);

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ----------------------------------------------------------
	// DRAM model, also drives the random ready signals
	// ----------------------------------------------------------
	always @(posedge Clock) begin : dramModel
		logic [entryWidth-1:0] beat;
		if (!rstN) begin
			DRAMCommandReady <= 1'b0;
			DRAMWriteDataReady <= 1'b0;
			DRAMReadDataValid <= 1'b0;
			DataOutReady <= 1'b0;
			readyRnd = seed;
			cycle = 0;
			wrSlot = 0;
			for (int b = 0; b < dramBuckets; b++) begin
				for (int s = 0; s < bucketSlots; s++) begin
					dramMem[b][s] = '0;
				end
			end
		end else begin
			cycle++;
			// Accepted command, logged for the path check
			if (DRAMCommandValid && DRAMCommandReady) begin
				cmdOps.push_back(DRAMCommand);
				cmdAddrs.push_back(DRAMAddress);
				if (DRAMCommand == dramRead) begin
					for (int s = 0; s < bucketSlots; s++) begin
						beatQ.push_back(dramMem[DRAMAddress][s]);
						beatTime.push_back(cycle + readDelay);
					end
				end else begin
					wrBucket = DRAMAddress;
					wrSlot = 0;
					wrBeats.push_back(0);
				end
			end
			// Write beats fill the bucket slot by slot
			if (DRAMWriteDataValid && DRAMWriteDataReady) begin
				dramMem[wrBucket][wrSlot] = DRAMWriteData;
				wrSlot++;
				if (wrBeats.size() != 0) begin
					wrBeats[wrBeats.size() - 1] += 1;
				end
			end
			// At most one return beat per cycle
			if (beatQ.size() != 0 && beatTime[0] <= cycle) begin
				beat = beatQ.pop_front();
				void'(beatTime.pop_front());
				DRAMReadData <= beat;
				DRAMReadDataValid <= 1'b1;
			end else begin
				DRAMReadDataValid <= 1'b0;
			end
			readyRnd = nextRandom(readyRnd);
			if (backPressure) begin
				DRAMCommandReady <= (readyRnd[1:0] != 2'b00);
				DRAMWriteDataReady <= (readyRnd[3:2] != 2'b00);
				DataOutReady <= readyRnd[4];
			end else begin
				DRAMCommandReady <= 1'b1;
				DRAMWriteDataReady <= 1'b1;
				DataOutReady <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	task automatic expectEqual(input string sig, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("** Error: %s got 0x%0h, expected 0x%0h", sig, got, exp);
		end
	endtask

	task automatic expectTrue(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Check failed: %s", what);
		end
	endtask

	// Reads root to leaf, then the same buckets leaf to root
	task automatic checkPathTraffic(input int cmdBase, input int beatBase);
		logic [bucketAddrWidth-1:0] parentIdx;
		int nCmds;
		nCmds = cmdOps.size() - cmdBase;
		expectEqual("DRAM command count", 32'(nCmds), 32'(2 * treeLevels));
		if (nCmds == 2 * treeLevels) begin
			expectEqual("DRAMAddress of root read", 32'(cmdAddrs[cmdBase]), 32'd0);
			for (int i = 0; i < 2 * treeLevels; i++) begin
				expectTrue(cmdOps[cmdBase + i] == ((i < treeLevels) ? dramRead : dramWrite),
					$sformatf("DRAM command %0d goes in the wrong direction", i));
			end
			for (int i = 1; i < treeLevels; i++) begin
				parentIdx = (cmdAddrs[cmdBase + i] - bucketAddrWidth'(1)) >> 1;
				expectTrue(cmdAddrs[cmdBase + i] != '0 && parentIdx == cmdAddrs[cmdBase + i - 1],
					$sformatf("read bucket %0d is not a child of the one before", i));
			end
			for (int i = 0; i < treeLevels; i++) begin
				expectEqual($sformatf("DRAMAddress of write %0d", i),
					32'(cmdAddrs[cmdBase + treeLevels + i]),
					32'(cmdAddrs[cmdBase + treeLevels - 1 - i]));
			end
		end
		for (int i = beatBase; i < wrBeats.size(); i++) begin
			expectEqual("DRAMWriteData beats per command", 32'(wrBeats[i]), 32'(bucketSlots));
		end
	endtask

	// ----------------------------------------------------------
	// One client access, returns the read result
	// ----------------------------------------------------------
	task automatic doAccess(input bit isWrite, input logic [addrWidth-1:0] addr,
		input logic [dataWidth-1:0] wdata, output logic [dataWidth-1:0] rdata);
		int waitCnt;
		int cmdBase;
		int beatBase;
		bit cmdDone;
		bit dataDone;
		bit gotData;
		bit earlyReady;
		rdata = '0;
		if (timedOut) begin
			return;
		end
		cmdBase = cmdOps.size();
		beatBase = wrBeats.size();
		@(posedge Clock);
		Cmd <= isWrite ? opWrite : opRead;
		PAddr <= addr;
		CmdValid <= 1'b1;
		DataIn <= wdata;
		DataInValid <= isWrite;
		cmdDone = 1'b0;
		dataDone = !isWrite;
		waitCnt = 0;
		// Command and data beat may be taken in different cycles
		while (!(cmdDone && dataDone) && waitCnt < waitLimit) begin
			@(posedge Clock);
			waitCnt++;
			if (CmdValid && CmdReady) begin
				cmdDone = 1'b1;
				CmdValid <= 1'b0;
			end
			if (DataInValid && DataInReady) begin
				dataDone = 1'b1;
				DataInValid <= 1'b0;
			end
		end
		if (!(cmdDone && dataDone)) begin
			$display("Timeout: command to address 0x%0h was not accepted", addr);
			timedOut = 1'b1;
			return;
		end
		gotData = isWrite;
		earlyReady = 1'b0;
		waitCnt = 0;
		do begin
			@(posedge Clock);
			waitCnt++;
			if (CmdReady && !gotData) begin
				earlyReady = 1'b1;
			end
			if (DataOutValid && DataOutReady && !gotData) begin
				rdata = DataOut;
				gotData = 1'b1;
			end
		end while (!(gotData && CmdReady) && waitCnt < waitLimit);
		if (!(gotData && CmdReady)) begin
			$display("Timeout: access to address 0x%0h did not finish", addr);
			timedOut = 1'b1;
			return;
		end
		expectTrue(!earlyReady, "CmdReady rose before the read result was taken");
		checkPathTraffic(cmdBase, beatBase);
	endtask

	// Directed operations with expected read values
	task automatic replayTrace();
		int fd;
		int n;
		int fields;
		int ops;
		int startErrors;
		logic [8*100-1:0] lineBuf;
		logic [3:0] op;
		logic [3:0] bp;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
		logic [dataWidth-1:0] expVal;
		logic [dataWidth-1:0] got;
		ops = 0;
		startErrors = errors;
		fd = $fopen("tests/oramTrace.txt", "r");
		expectTrue(fd != 0, "could not open tests/oramTrace.txt");
		if (fd == 0) begin
			return;
		end
		while (!timedOut && !$feof(fd)) begin
			lineBuf = '0;
			n = $fgets(lineBuf, fd);
			fields = $sscanf(lineBuf, "%h %h %h %h %h", op, addr, wdata, expVal, bp);
			// Comment and blank lines do not parse
			if (n != 0 && fields == 5) begin
				backPressure <= (bp != 4'd0);
				doAccess(op != 4'd0, addr, wdata, got);
				if (op != 4'd0) begin
					shadow[addr] = wdata;
				end else if (!timedOut) begin
					expectEqual($sformatf("DataOut addr 0x%0h", addr), 32'(got), 32'(expVal));
				end
				ops++;
			end
		end
		$fclose(fd);
		$display("Test directed trace: %0d accesses, %0d errors", ops, errors - startErrors);
	endtask

	task automatic randomAccesses(input string name, input bit pressure);
		int startErrors;
		bit isWrite;
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
		logic [dataWidth-1:0] got;
		startErrors = errors;
		backPressure <= pressure;
		for (int i = 0; i < randomOps && !timedOut; i++) begin
			opsRnd = nextRandom(opsRnd);
			isWrite = opsRnd[0];
			addr = opsRnd[3:1];
			wdata = opsRnd[31:16];
			doAccess(isWrite, addr, wdata, got);
			if (isWrite) begin
				shadow[addr] = wdata;
			end else if (!timedOut) begin
				expectEqual($sformatf("DataOut addr 0x%0h", addr), 32'(got), 32'(shadow[addr]));
			end
		end
		$display("Test %s: %0d accesses, %0d errors", name, randomOps, errors - startErrors);
	endtask

	// ----------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------
	initial begin
		rstN = 1'b0;
		Cmd = opRead;
		PAddr = '0;
		CmdValid = 1'b0;
		DataIn = '0;
		DataInValid = 1'b0;
		checks = 0;
		errors = 0;
		timedOut = 1'b0;
		opsRnd = seed;
		for (int i = 0; i < 2**addrWidth; i++) begin
			shadow[i] = '0;
		end
		repeat (4) @(posedge Clock);
		rstN <= 1'b1;
		@(posedge Clock);
		replayTrace();
		randomAccesses("random", 1'b0);
		randomAccesses("random with back-pressure", 1'b1);
		$display("Summary: %0d checks, %0d errors%s", checks, errors,
			timedOut ? ", stopped by a timeout" : "");
		if (timedOut || errors != 0) begin
			$display("TEST FAIL");
		end else begin
			$display("TEST PASS");
		end
		$finish;
	end

endmodule

//--- tests/pathOramTop_checker.sv
// ----------------------------------------------------------
// Handshake properties only; needs assertions enabled
// ----------------------------------------------------------
module pathOramTop_checker import oramPkg::*; (
	input logic Clock,
	input logic rstN,
	input logic CmdReady,
	input logic [dataWidth-1:0] DataOut,
	input logic DataOutValid,
	input logic DataOutReady,
	input logic [bucketAddrWidth-1:0] DRAMAddress,
	input logic DRAMCommandValid,
	input logic DRAMCommandReady,
	input logic [entryWidth-1:0] DRAMWriteData,
	input logic DRAMWriteDataValid,
	input logic DRAMWriteDataReady
);

	// Read result waits for the client
	dataOutHold: assert property (@(posedge Clock) disable iff (!rstN)
		DataOutValid && !DataOutReady |=> DataOutValid && $stable(DataOut))
		else $error("DataOut dropped or changed before DataOutReady");

	// Bucket command waits for DRAM
	dramCmdHold: assert property (@(posedge Clock) disable iff (!rstN)
		DRAMCommandValid && !DRAMCommandReady |=> DRAMCommandValid && $stable(DRAMAddress))
		else $error("DRAM command dropped or changed before DRAMCommandReady");

	dramWriteHold: assert property (@(posedge Clock) disable iff (!rstN)
		DRAMWriteDataValid && !DRAMWriteDataReady |=> DRAMWriteDataValid && $stable(DRAMWriteData))
		else $error("DRAMWriteData dropped or changed under back-pressure");

	// One access in flight
	busyDuringDram: assert property (@(posedge Clock) disable iff (!rstN)
		DRAMCommandValid |-> !CmdReady)
		else $error("CmdReady high while a DRAM command is pending");

endmodule
